// ==== dv/tb_clk_gen.sv ====
module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 8 time unit period
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    // Reset held low over the first two rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

// ==== dv/tb_periph_top.sv ====
module tb_periph_top;

    localparam int unsigned CLKS_PER_BIT   = 8;
    localparam int unsigned FRAME_CYCLES   = 10 * CLKS_PER_BIT;
    localparam int unsigned NUM_TESTS      = 6;
    localparam int unsigned TIMEOUT_CYCLES = NUM_TESTS * (20 * FRAME_CYCLES + 200);

    localparam logic [periph_pkg::ADDR_W-1:0] UART_BASE =
        periph_pkg::ADDR_W'(1) << periph_pkg::WIN_BIT;

    logic                clk;
    logic                rst_n;
    periph_pkg::wb_req_t wb_req;
    periph_pkg::wb_rsp_t wb_rsp;
    logic                uart_rx;
    logic                uart_tx;

    // Expected and observed traffic, drained by the comparing process
    periph_pkg::wb_rsp_t exp_rsp_q[$];
    periph_pkg::wb_rsp_t got_rsp_q[$];
    logic [7:0]          exp_tx_q[$];
    logic [7:0]          got_tx_q[$];

    // Register model state
    logic [7:0] model_rx_byte   = 8'h00;
    logic       model_rx_valid  = 1'b0;
    logic       model_overrun   = 1'b0;
    logic       model_frame_err = 1'b0;
    logic       model_tx_busy   = 1'b0;

    integer seed          = 85;
    int     cycle_cnt     = 0;
    int     rx_strobe_cnt = 0;

    tb_clk_gen clk_gen0 (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    periph_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) dut0 (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .wb_req_i  (wb_req),
        .wb_rsp_o  (wb_rsp),
        .uart_rx_i (uart_rx),
        .uart_tx_o (uart_tx)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    function automatic logic in_window(input logic [periph_pkg::ADDR_W-1:0] adr);
        return (adr >> periph_pkg::WIN_BIT) == 1;
    endfunction

    // Expected read response, with the read side effects on the flags
    function automatic periph_pkg::wb_rsp_t ref_read(input logic [periph_pkg::ADDR_W-1:0] adr);
        periph_pkg::wb_rsp_t               rsp;
        logic [periph_pkg::WIN_ADDR_W-1:0] off;
        rsp = '0;
        off = adr[periph_pkg::WIN_ADDR_W-1:0];
        if (!in_window(adr)) begin
            rsp.err = 1'b1;
        end else begin
            rsp.ack = 1'b1;
            case (off)
                periph_pkg::REG_RXDATA: begin
                    rsp.dat[7:0]   = model_rx_byte;
                    model_rx_valid = 1'b0;
                    model_overrun  = 1'b0;
                end
                periph_pkg::REG_STATUS: begin
                    rsp.dat[periph_pkg::STAT_TX_BUSY]    = model_tx_busy;
                    rsp.dat[periph_pkg::STAT_RX_VALID]   = model_rx_valid;
                    rsp.dat[periph_pkg::STAT_RX_OVERRUN] = model_overrun;
                    rsp.dat[periph_pkg::STAT_FRAME_ERR]  = model_frame_err;
                    model_frame_err = 1'b0;
                end
                default: rsp.dat = '0;
            endcase
        end
        return rsp;
    endfunction

    function automatic periph_pkg::wb_rsp_t expect_write(
        input logic [periph_pkg::ADDR_W-1:0] adr,
        input logic [periph_pkg::DATA_W-1:0] dat,
        input logic [periph_pkg::SEL_W-1:0]  sel
    );
        periph_pkg::wb_rsp_t rsp;
        rsp = '0;
        if (!in_window(adr)) begin
            rsp.err = 1'b1;
        end else begin
            rsp.ack = 1'b1;
            if (adr[periph_pkg::WIN_ADDR_W-1:0] == periph_pkg::REG_TXDATA && sel[0]) begin
                exp_tx_q.push_back(dat[7:0]);
                model_tx_busy = 1'b1;
            end
        end
        return rsp;
    endfunction

    function automatic void apply_rx_frame(input logic [7:0] b, input logic stop_bit);
        if (stop_bit) begin
            if (model_rx_valid) begin
                model_overrun = 1'b1;
            end
            model_rx_byte  = b;
            model_rx_valid = 1'b1;
        end else begin
            model_frame_err = 1'b1;
        end
    endfunction

    ////////////////////
    // Bus master
    ////////////////////

    task automatic drive_transfer(
        input logic                          we,
        input logic [periph_pkg::ADDR_W-1:0] adr,
        input logic [periph_pkg::DATA_W-1:0] dat,
        input logic [periph_pkg::SEL_W-1:0]  sel
    );
        periph_pkg::wb_rsp_t got;
        periph_pkg::wb_rsp_t exp;
        exp = we ? expect_write(adr, dat, sel) : ref_read(adr);
        exp_rsp_q.push_back(exp);
        @(posedge clk);
        #1;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = dat;
        wb_req.sel = sel;
        // Response sampled mid-cycle, request held through the ack edge
        do begin
            @(negedge clk);
            got = wb_rsp;
        end while (!(got.ack || got.err));
        @(posedge clk);
        #1;
        wb_req = '0;
        got_rsp_q.push_back(got);
    endtask

    task automatic write_reg(
        input logic [periph_pkg::ADDR_W-1:0] adr,
        input logic [periph_pkg::DATA_W-1:0] dat,
        input logic [periph_pkg::SEL_W-1:0]  sel
    );
        drive_transfer(1'b1, adr, dat, sel);
    endtask

    task automatic read_reg(input logic [periph_pkg::ADDR_W-1:0] adr);
        drive_transfer(1'b0, adr, '0, '1);
    endtask

    ////////////////////
    // Serial models
    ////////////////////

    always @(posedge clk) begin
        if (dut0.rx_strobe) begin
            rx_strobe_cnt <= rx_strobe_cnt + 1;
        end
    end

    task automatic send_frame(input logic [7:0] b, input logic stop_bit);
        logic [9:0] frame;
        int         target;
        frame  = {stop_bit, b, 1'b0};
        target = rx_strobe_cnt + 1;
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #1;
            uart_rx = frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
        @(posedge clk);
        #1;
        uart_rx = 1'b1;
        while (rx_strobe_cnt != target) @(posedge clk);
        apply_rx_frame(b, stop_bit);
    endtask

    // Mid-bit sampling of uart_tx_o
    initial begin : tx_monitor
        logic [7:0] b;
        wait (rst_n);
        forever begin
            @(negedge uart_tx);
            repeat (CLKS_PER_BIT / 2) @(posedge clk);
            assert (uart_tx == 1'b0)
                else abort_run("Start bit on uart_tx_o did not stay low to mid-bit");
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS_PER_BIT) @(posedge clk);
                b[i] = uart_tx;
            end
            repeat (CLKS_PER_BIT) @(posedge clk);
            assert (uart_tx == 1'b1)
                else abort_run("Frame on uart_tx_o ended without a high stop bit");
            got_tx_q.push_back(b);
        end
    end

    ////////////////////
    // Comparing process
    ////////////////////

    always @(posedge clk) begin : compare_proc
        periph_pkg::wb_rsp_t exp;
        periph_pkg::wb_rsp_t got;
        logic [7:0]          exp_b;
        logic [7:0]          got_b;
        while (exp_rsp_q.size() > 0 && got_rsp_q.size() > 0) begin
            exp = exp_rsp_q.pop_front();
            got = got_rsp_q.pop_front();
            assert (got.ack == exp.ack)
                else abort_run($sformatf("[FAIL] wb_rsp_o.ack got 0x%0h exp 0x%0h",
                                         got.ack, exp.ack));
            assert (got.err == exp.err)
                else abort_run($sformatf("[FAIL] wb_rsp_o.err got 0x%0h exp 0x%0h",
                                         got.err, exp.err));
            assert (got.dat == exp.dat)
                else abort_run($sformatf("[FAIL] wb_rsp_o.dat got 0x%08h exp 0x%08h",
                                         got.dat, exp.dat));
        end
        while (got_tx_q.size() > 0) begin
            got_b = got_tx_q.pop_front();
            assert (exp_tx_q.size() > 0)
                else abort_run("A frame appeared on uart_tx_o that no TXDATA write requested");
            exp_b = exp_tx_q.pop_front();
            assert (got_b == exp_b)
                else abort_run($sformatf("[FAIL] uart_tx_o byte got 0x%02h exp 0x%02h",
                                         got_b, exp_b));
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run("Timeout: the tests did not finish within the cycle limit");
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin : stimulus
        logic [7:0] b;
        wb_req  = '0;
        uart_rx = 1'b1;
        wait (rst_n);
        @(posedge clk);

        $display("Test 1: transmit");
        b = 8'($random(seed));
        write_reg(UART_BASE + periph_pkg::REG_TXDATA, {24'h0, b}, 4'hF);
        read_reg(UART_BASE + periph_pkg::REG_STATUS);
        for (int i = 0; i < 3; i++) begin
            b = 8'($random(seed));
            write_reg(UART_BASE + periph_pkg::REG_TXDATA, {24'h0, b}, 4'h1);
        end
        while (exp_tx_q.size() > 0) @(posedge clk);
        while (dut0.tx_busy) @(posedge clk);
        model_tx_busy = 1'b0;

        $display("Test 2: ignored write");
        b = 8'($random(seed));
        write_reg(UART_BASE + periph_pkg::REG_TXDATA, {24'h0, b}, 4'hE);
        repeat (2 * FRAME_CYCLES) @(posedge clk);
        assert (got_tx_q.size() == 0 && !dut0.tx_busy)
            else abort_run("A TXDATA write with sel[0] clear started a frame");

        $display("Test 3: receive");
        send_frame(8'($random(seed)), 1'b1);
        read_reg(UART_BASE + periph_pkg::REG_STATUS);
        read_reg(UART_BASE + periph_pkg::REG_RXDATA);
        read_reg(UART_BASE + periph_pkg::REG_STATUS);

        $display("Test 4: overrun");
        send_frame(8'($random(seed)), 1'b1);
        send_frame(8'($random(seed)), 1'b1);
        read_reg(UART_BASE + periph_pkg::REG_STATUS);
        read_reg(UART_BASE + periph_pkg::REG_RXDATA);
        read_reg(UART_BASE + periph_pkg::REG_STATUS);

        $display("Test 5: framing error");
        send_frame(8'($random(seed)), 1'b0);
        read_reg(UART_BASE + periph_pkg::REG_STATUS);
        read_reg(UART_BASE + periph_pkg::REG_STATUS);

        $display("Test 6: unmapped access");
        read_reg(20'h00008);
        write_reg(20'h20000, 32'h0000_005A, 4'hF);
        read_reg(20'hF0004);
        write_reg(20'h00000, 32'h0000_00A5, 4'hF);
        read_reg(UART_BASE + 20'h0000C);
        write_reg(UART_BASE + 20'h00010, 32'hDEAD_BEEF, 4'hF);
        read_reg(UART_BASE + periph_pkg::REG_TXDATA);

        while (exp_rsp_q.size() > 0 || got_rsp_q.size() > 0) @(posedge clk);
        @(posedge clk);
        if (exp_tx_q.size() == 0 && got_tx_q.size() == 0 && uart_tx == 1'b1) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            abort_run("Transmit traffic was left over at the end of the run");
        end
    end

endmodule

// ==== periph_top.f ====
rtl/periph_pkg.sv
rtl/periph_decoder.sv
rtl/uart_regs.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/periph_top.sv
dv/tb_clk_gen.sv
dv/tb_periph_top.sv

// ==== rtl/periph_decoder.sv ====
module periph_decoder (
    input  logic                clk_i,
    input  logic                rst_n_i,

    // Host side with the full bus address
    input  periph_pkg::wb_req_t host_req_i,
    output periph_pkg::wb_rsp_t host_rsp_o,

    // Device side sees the offset inside the window
    output periph_pkg::wb_req_t dev_req_o,
    input  periph_pkg::wb_rsp_t dev_rsp_i
);

    localparam int unsigned IDX_W = periph_pkg::ADDR_W - periph_pkg::WIN_BIT;

    localparam logic [IDX_W-1:0] WIN_IDX = IDX_W'(1);
    localparam logic [periph_pkg::ADDR_W-1:0] WIN_BASE =
        periph_pkg::ADDR_W'(1) << periph_pkg::WIN_BIT;

    logic hit;
    logic err_q;

    ////////////////////
    // Window match
    ////////////////////

    assign hit = (host_req_i.adr[periph_pkg::ADDR_W-1:periph_pkg::WIN_BIT] == WIN_IDX);

    // Forward with the base removed and the strobe held low outside the window
    always_comb begin
        dev_req_o     = host_req_i;
        dev_req_o.cyc = host_req_i.cyc & hit;
        dev_req_o.stb = host_req_i.stb & hit;
        dev_req_o.adr = host_req_i.adr - WIN_BASE;
    end

    ////////////////////
    // Decode error
    ////////////////////

    // One-cycle err pulse that lands while the master still holds stb
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= host_req_i.cyc & host_req_i.stb & ~hit & ~err_q;
        end
    end

    always_comb begin
        host_rsp_o.ack = dev_rsp_i.ack;
        host_rsp_o.err = err_q | dev_rsp_i.err;
        host_rsp_o.dat = err_q ? '0 : dev_rsp_i.dat;
    end

    // The device ack and the local err must never overlap
    a_ack_err_excl : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(host_rsp_o.ack && host_rsp_o.err)
    );

endmodule

// ==== rtl/periph_pkg.sv ====
package periph_pkg;

    ////////////////////
    // Bus geometry
    ////////////////////

    localparam int unsigned ADDR_W = 20;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned SEL_W  = 4;

    // UART window starts at 1 << WIN_BIT
    localparam int unsigned WIN_BIT    = 16;
    localparam int unsigned WIN_ADDR_W = WIN_BIT;

    ////////////////////
    // UART registers
    ////////////////////

    localparam logic [WIN_ADDR_W-1:0] REG_TXDATA = WIN_ADDR_W'('h0);
    localparam logic [WIN_ADDR_W-1:0] REG_RXDATA = WIN_ADDR_W'('h4);
    localparam logic [WIN_ADDR_W-1:0] REG_STATUS = WIN_ADDR_W'('h8);

    // STATUS bit positions
    localparam int unsigned STAT_TX_BUSY    = 0;
    localparam int unsigned STAT_RX_VALID   = 1;
    localparam int unsigned STAT_RX_OVERRUN = 2;
    localparam int unsigned STAT_FRAME_ERR  = 3;

    ////////////////////
    // Wishbone classic
    ////////////////////

    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [ADDR_W-1:0] adr;
        logic [DATA_W-1:0] dat;
        logic [SEL_W-1:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] dat;
        logic              ack;
        logic              err;
    } wb_rsp_t;

endpackage

// ==== rtl/periph_top.sv ====
module periph_top #(
    parameter int unsigned CLKS_PER_BIT = 16
) (
    input  logic                clk_i,
    input  logic                rst_n_i,

    input  periph_pkg::wb_req_t wb_req_i,
    output periph_pkg::wb_rsp_t wb_rsp_o,

    input  logic                uart_rx_i,
    output logic                uart_tx_o
);

    // Decoder to UART register block
    periph_pkg::wb_req_t uart_req;
    periph_pkg::wb_rsp_t uart_rsp;

    // Register block to serial engines
    logic       tx_start;
    logic [7:0] tx_byte;
    logic       tx_busy;
    logic       rx_strobe;
    logic [7:0] rx_byte;
    logic       rx_frame_err;

    periph_decoder decoder0 (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .host_req_i (wb_req_i),
        .host_rsp_o (wb_rsp_o),
        .dev_req_o  (uart_req),
        .dev_rsp_i  (uart_rsp)
    );

    uart_regs regs0 (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .req_i          (uart_req),
        .rsp_o          (uart_rsp),
        .tx_start_o     (tx_start),
        .tx_byte_o      (tx_byte),
        .tx_busy_i      (tx_busy),
        .rx_strobe_i    (rx_strobe),
        .rx_byte_i      (rx_byte),
        .rx_frame_err_i (rx_frame_err)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) tx0 (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .start_i (tx_start),
        .byte_i  (tx_byte),
        .busy_o  (tx_busy),
        .tx_o    (uart_tx_o)
    );

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) rx0 (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .rx_i        (uart_rx_i),
        .strobe_o    (rx_strobe),
        .byte_o      (rx_byte),
        .frame_err_o (rx_frame_err)
    );

endmodule

// ==== rtl/uart_regs.sv ====
module uart_regs (
    input  logic                clk_i,
    input  logic                rst_n_i,

    input  periph_pkg::wb_req_t req_i,
    output periph_pkg::wb_rsp_t rsp_o,

    output logic                tx_start_o,
    output logic [7:0]          tx_byte_o,
    input  logic                tx_busy_i,

    input  logic                rx_strobe_i,
    input  logic [7:0]          rx_byte_i,
    input  logic                rx_frame_err_i
);

    logic [periph_pkg::WIN_ADDR_W-1:0] offset;
    logic [periph_pkg::DATA_W-1:0]     status;
    logic [periph_pkg::DATA_W-1:0]     rd_mux;
    logic [periph_pkg::DATA_W-1:0]     rdata_q;

    logic access;
    logic tx_wr;
    logic tx_ready;
    logic do_ack;
    logic rd_rxdata;
    logic rd_status;
    logic rx_good;

    logic       ack_q;
    logic       tx_start_q;
    logic [7:0] tx_byte_q;
    logic [7:0] rx_byte_q;
    logic       rx_valid_q;
    logic       overrun_q;
    logic       frame_err_q;

    ////////////////////
    // Access decode
    ////////////////////

    assign offset = req_i.adr[periph_pkg::WIN_ADDR_W-1:0];

    // New cycle only, ack_q blocks a second hit on the held request
    assign access = req_i.cyc & req_i.stb & ~ack_q;
    assign tx_wr  = access & req_i.we & req_i.sel[0] & (offset == periph_pkg::REG_TXDATA);

    // Wait states until the transmitter frees up
    assign tx_ready = ~tx_busy_i & ~tx_start_q;
    assign do_ack   = access & (~tx_wr | tx_ready);

    assign rd_rxdata = do_ack & ~req_i.we & (offset == periph_pkg::REG_RXDATA);
    assign rd_status = do_ack & ~req_i.we & (offset == periph_pkg::REG_STATUS);
    assign rx_good   = rx_strobe_i & ~rx_frame_err_i;

    always_comb begin
        status = '0;
        status[periph_pkg::STAT_TX_BUSY]    = tx_busy_i | tx_start_q;
        status[periph_pkg::STAT_RX_VALID]   = rx_valid_q;
        status[periph_pkg::STAT_RX_OVERRUN] = overrun_q;
        status[periph_pkg::STAT_FRAME_ERR]  = frame_err_q;
    end

    always_comb begin
        case (offset)
            periph_pkg::REG_RXDATA: rd_mux = {{(periph_pkg::DATA_W-8){1'b0}}, rx_byte_q};
            periph_pkg::REG_STATUS: rd_mux = status;
            default:                rd_mux = '0;
        endcase
    end

    ////////////////////
    // Control state
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_q       <= 1'b0;
            tx_start_q  <= 1'b0;
            rx_byte_q   <= 8'h00;
            rx_valid_q  <= 1'b0;
            overrun_q   <= 1'b0;
            frame_err_q <= 1'b0;
        end else begin
            ack_q      <= do_ack;
            tx_start_q <= tx_wr & tx_ready;

            if (rd_rxdata) begin
                rx_valid_q <= 1'b0;
                overrun_q  <= 1'b0;
            end
            if (rd_status) begin
                frame_err_q <= 1'b0;
            end

            // Arrival wins over a same-cycle clear
            if (rx_good) begin
                rx_byte_q  <= rx_byte_i;
                rx_valid_q <= 1'b1;
                if (rx_valid_q && !rd_rxdata) begin
                    overrun_q <= 1'b1;
                end
            end
            if (rx_strobe_i && rx_frame_err_i) begin
                frame_err_q <= 1'b1;
            end
        end
    end

    // Payload
    always_ff @(posedge clk_i) begin
        if (tx_wr && tx_ready) begin
            tx_byte_q <= req_i.dat[7:0];
        end
        if (do_ack) begin
            rdata_q <= req_i.we ? '0 : rd_mux;
        end
    end

    assign tx_start_o = tx_start_q;
    assign tx_byte_o  = tx_byte_q;

    always_comb begin
        rsp_o.dat = rdata_q;
        rsp_o.ack = ack_q;
        rsp_o.err = 1'b0;
    end

    a_ack_in_cycle : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        rsp_o.ack |-> (req_i.cyc && req_i.stb)
    );

    // A start while a frame runs would be lost by the transmitter
    a_no_start_busy : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        tx_start_o |-> !tx_busy_i
    );

endmodule

// ==== rtl/uart_rx.sv ====
module uart_rx #(
    parameter int unsigned CLKS_PER_BIT = 16
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       rx_i,
    output logic       strobe_o,
    output logic [7:0] byte_o,
    output logic       frame_err_o
);

    localparam int unsigned CNT_W = $clog2(CLKS_PER_BIT + 1);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t        state_q;
    logic [2:0]       sync_q;
    logic [CNT_W-1:0] cnt_q;
    logic [2:0]       bit_idx_q;
    logic [7:0]       shift_q;
    logic             strobe_q;
    logic             frame_err_q;
    logic             rx_s;
    logic             fall;
    logic             half_end;
    logic             bit_end;

    ////////////////////
    // Synchronizer
    ////////////////////

    // Two flops for metastability, third one for edge detect
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sync_q <= 3'b111;
        end else begin
            sync_q <= {sync_q[1:0], rx_i};
        end
    end

    assign rx_s     = sync_q[1];
    assign fall     = sync_q[2] & ~sync_q[1];
    assign half_end = (cnt_q == CNT_W'(CLKS_PER_BIT / 2 - 1));
    assign bit_end  = (cnt_q == CNT_W'(CLKS_PER_BIT - 1));

    ////////////////////
    // Frame FSM
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= RX_IDLE;
            cnt_q       <= '0;
            bit_idx_q   <= 3'd0;
            strobe_q    <= 1'b0;
            frame_err_q <= 1'b0;
        end else begin
            strobe_q <= 1'b0;
            cnt_q    <= cnt_q + CNT_W'(1);
            case (state_q)
                RX_IDLE: begin
                    cnt_q <= '0;
                    if (fall) begin
                        state_q <= RX_START;
                    end
                end
                RX_START: begin
                    // Glitch check at the middle of the start bit
                    if (half_end) begin
                        cnt_q     <= '0;
                        bit_idx_q <= 3'd0;
                        state_q   <= rx_s ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        cnt_q     <= '0;
                        bit_idx_q <= bit_idx_q + 3'd1;
                        if (bit_idx_q == 3'd7) begin
                            state_q <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        strobe_q    <= 1'b1;
                        frame_err_q <= ~rx_s;
                        state_q     <= RX_IDLE;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // Data shift, LSB arrives first
    always_ff @(posedge clk_i) begin
        if (state_q == RX_DATA && bit_end) begin
            shift_q <= {rx_s, shift_q[7:1]};
        end
    end

    assign strobe_o    = strobe_q;
    assign byte_o      = shift_q;
    assign frame_err_o = frame_err_q;

endmodule

// ==== rtl/uart_tx.sv ====
module uart_tx #(
    parameter int unsigned CLKS_PER_BIT = 16
) (
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       start_i,
    input  logic [7:0] byte_i,
    output logic       busy_o,
    output logic       tx_o
);

    localparam int unsigned CNT_W = $clog2(CLKS_PER_BIT + 1);

    logic [CNT_W-1:0] cnt_q;
    logic [3:0]       bit_idx_q;
    logic [9:0]       shift_q;
    logic             busy_q;
    logic             bit_end;

    assign bit_end = (cnt_q == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q    <= 1'b0;
            cnt_q     <= '0;
            bit_idx_q <= 4'd0;
            shift_q   <= '1;
        end else if (!busy_q) begin
            if (start_i) begin
                // Stop, data LSB first, start
                shift_q   <= {1'b1, byte_i, 1'b0};
                busy_q    <= 1'b1;
                cnt_q     <= '0;
                bit_idx_q <= 4'd0;
            end
        end else if (bit_end) begin
            cnt_q   <= '0;
            // Ones fill in behind, line idles high
            shift_q <= {1'b1, shift_q[9:1]};
            if (bit_idx_q == 4'd9) begin
                busy_q <= 1'b0;
            end else begin
                bit_idx_q <= bit_idx_q + 4'd1;
            end
        end else begin
            cnt_q <= cnt_q + CNT_W'(1);
        end
    end

    assign busy_o = busy_q;
    assign tx_o   = shift_q[0];

    a_idle_high : assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !busy_o |-> tx_o
    );

endmodule
